// ==== project.f ====
+incdir+common
common/fir_pkg.sv
fir/fir_filter.sv
fir/fir_coef_bank.sv
src/fir_output_scaler.sv
src/fir_subsys_top.sv
testbench/tb_fir_subsys.sv

// ==== Bender.yml ====
package:
  name: fir_subsys

export_include_dirs:
  - common

sources:
  - common/fir_pkg.sv
  - fir/fir_filter.sv
  - fir/fir_coef_bank.sv
  - src/fir_output_scaler.sv
  - src/fir_subsys_top.sv
  - target: test
    files:
      - testbench/tb_fir_subsys.sv

// ==== testbench/tb_fir_subsys.sv ====
`timescale 1ns/1ps
//##########################################################
// Table-driven testbench of the two-channel FIR subsystem
//##########################################################
`include "fir_defines.svh"

module tb_fir_subsys
    import fir_pkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 4;
    localparam int LATENCY      = 5;
    localparam int DRAIN_LIMIT  = 20;
    localparam int MARGIN       = 50;
    localparam logic [31:0] LFSR_SEED = 32'h6cc70a2a;
    localparam logic [31:0] LFSR_MASK = 32'hB4BCD35C;

    localparam int OP_WR    = 0;
    localparam int OP_RD    = 1;
    localparam int OP_BURST = 2;
    localparam int OP_EN    = 3;

    localparam int KIND_IMPULSE = 0;
    localparam int KIND_RANDOM  = 1;
    localparam int KIND_FULL    = 2;

    // For bursts the data field holds the sample kind
    typedef struct packed {
        logic [1:0] op;
        apb_addr_t  addr;
        apb_data_t  data;
        logic       err;
        logic [7:0] count;
    } entry_t;

    logic                       clk;
    logic                       rst;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    apb_addr_t                  paddr;
    apb_data_t                  pwdata;
    apb_data_t                  prdata;
    logic                       pready;
    logic                       pslverr;
    logic                       tvalid_i;
    sample_t [`FIR_CH_NUM-1:0]  tdata_i;
    logic                       tvalid_o;
    sample_t [`FIR_CH_NUM-1:0]  tdata_o;

    entry_t                     table_q[$];
    sample_t [`FIR_CH_NUM-1:0]  exp_q[$];
    int                         exp_cyc_q[$];
    coef_t                      m_coef [`FIR_TAP_NUM];
    sample_t                    m_hist [`FIR_CH_NUM][`FIR_TAP_NUM];
    logic                       m_en;
    shift_t                     m_shift;
    logic [31:0]                lfsr_q;
    int                         cycle;
    int                         cycle_limit;
    int                         value_errors;
    int                         proto_errors;

    fir_subsys_top uut (
        .clk_i     (clk),
        .rst_i     (rst),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr),
        .tvalid_i  (tvalid_i),
        .tdata_i   (tdata_i),
        .tvalid_o  (tvalid_o),
        .tdata_o   (tdata_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    //##########################################################
    // Reference model
    //##########################################################

    function automatic logic next_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ LFSR_MASK;
        end
        return b;
    endfunction

    function automatic sample_t random_sample();
        sample_t s;
        for (int i = 0; i < `FIR_DATA_W; i++) begin
            s[i] = next_bit();
        end
        return s;
    endfunction

    // Round half up, shift right and clamp to the sample range
    function automatic sample_t scale(longint acc, int s);
        longint y;
        if (s == 0) begin
            y = acc;
        end else begin
            y = (acc + (longint'(1) << (s - 1))) >>> s;
        end
        if (y > 32767) begin
            y = 32767;
        end else if (y < -32768) begin
            y = -32768;
        end
        return sample_t'(y);
    endfunction

    function automatic void apply_write(apb_addr_t addr, apb_data_t data);
        if (addr == 8'h00) begin
            m_en    = data[0];
            m_shift = data[13:8];
        end else if (addr >= 8'h40 && addr < 8'h60 && addr[1:0] == 2'b00) begin
            m_coef[(addr - 8'h40) / 4] = data[17:0];
        end
    endfunction

    function automatic void model_accept(sample_t [`FIR_CH_NUM-1:0] x, int edge_cyc);
        sample_t [`FIR_CH_NUM-1:0] y;
        longint acc;
        for (int ch = 0; ch < `FIR_CH_NUM; ch++) begin
            for (int k = `FIR_TAP_NUM - 1; k > 0; k--) begin
                m_hist[ch][k] = m_hist[ch][k-1];
            end
            m_hist[ch][0] = x[ch];
            acc = 0;
            for (int k = 0; k < `FIR_TAP_NUM; k++) begin
                acc += longint'(m_coef[k]) * longint'(m_hist[ch][k]);
            end
            y[ch] = scale(acc, int'(m_shift));
        end
        exp_q.push_back(y);
        exp_cyc_q.push_back(edge_cyc + LATENCY);
    endfunction

    //##########################################################
    // Drivers
    //##########################################################

    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic apb_access(apb_addr_t addr, apb_data_t data, logic write,
                              apb_data_t exp_data, logic exp_err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        assert (pready === 1'b0 && prdata === '0)
            else begin
                proto_errors++;
                $display("APB slave responded during the setup phase at %0t", $time);
            end
        step();
        penable = 1'b1;
        @(negedge clk);
        assert (pready === 1'b1)
            else begin
                proto_errors++;
                $display("APB pready stayed low in the access phase at %0t", $time);
            end
        assert (pslverr === exp_err)
            else begin
                value_errors++;
                $display("ERR %0t pslverr_o expected %0b actual %0b", $time, exp_err, pslverr);
            end
        if (!write) begin
            assert (prdata === exp_data)
                else begin
                    value_errors++;
                    $display("ERR %0t prdata_o expected %h actual %h", $time, exp_data, prdata);
                end
        end
        step();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic send_burst(int kind, int count);
        sample_t [`FIR_CH_NUM-1:0] x;
        for (int i = 0; i < count; i++) begin
            for (int ch = 0; ch < `FIR_CH_NUM; ch++) begin
                if (kind == KIND_RANDOM) begin
                    x[ch] = random_sample();
                end else if (kind == KIND_FULL) begin
                    x[ch] = (ch % 2 == 0) ? 16'sh7fff : 16'sh8000;
                end else begin
                    x[ch] = (ch == 0 && i == 0) ? 16'sd1 : 16'sd0;
                end
            end
            tvalid_i = 1'b1;
            tdata_i  = x;
            if (m_en) begin
                model_accept(x, cycle + 1);
            end
            step();
        end
        tvalid_i = 1'b0;
        tdata_i  = '0;
        for (int n = 0; n < DRAIN_LIMIT && exp_q.size() != 0; n++) begin
            @(posedge clk);
        end
        assert (exp_q.size() == 0)
            else begin
                proto_errors++;
                $display("%0d expected outputs never arrived", exp_q.size());
            end
        // Idle long enough to catch any stray output
        repeat (LATENCY + 2) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic run_entry(entry_t e);
        apb_data_t d;
        case (e.op)
            OP_WR: begin
                apb_access(e.addr, e.data, 1'b1, '0, 1'b0);
                apply_write(e.addr, e.data);
            end
            OP_RD: begin
                for (int i = 0; i < e.count; i++) begin
                    apb_access(apb_addr_t'(e.addr + 4 * i), '0, 1'b0, e.data, e.err);
                end
            end
            OP_EN: begin
                d       = '0;
                d[0]    = e.data[0];
                d[13:8] = m_shift;
                apb_access(8'h00, d, 1'b1, '0, 1'b0);
                apply_write(8'h00, d);
            end
            default: send_burst(int'(e.data), int'(e.count));
        endcase
    endtask

    task automatic add_entry(int op, apb_addr_t addr, apb_data_t data, logic err, int count);
        table_q.push_back('{op[1:0], addr, data, err, count[7:0]});
        cycle_limit += (op == OP_BURST) ? count + DRAIN_LIMIT + LATENCY + 3 : 2 * count;
    endtask

    task automatic finish_run();
        $display("Errors: %0d value, %0d protocol", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    //##########################################################
    // Monitor and watchdog
    //##########################################################

    always @(negedge clk) begin
        sample_t [`FIR_CH_NUM-1:0] exp;
        int exp_cyc;
        if (!rst && tvalid_o === 1'b1) begin
            assert (exp_q.size() != 0)
                else begin
                    proto_errors++;
                    $display("Output at %0t with no accepted sample in flight", $time);
                end
            if (exp_q.size() != 0) begin
                exp     = exp_q.pop_front();
                exp_cyc = exp_cyc_q.pop_front();
                for (int ch = 0; ch < `FIR_CH_NUM; ch++) begin
                    assert (tdata_o[ch] === exp[ch])
                        else begin
                            value_errors++;
                            $display("ERR %0t tdata_o[%0d] expected %0d actual %0d",
                                     $time, ch, exp[ch], tdata_o[ch]);
                        end
                end
                assert (cycle == exp_cyc)
                    else begin
                        value_errors++;
                        $display("ERR %0t tvalid_o cycle expected %0d actual %0d",
                                 $time, exp_cyc, cycle);
                    end
            end
        end
    end

    always @(posedge clk) begin
        if (cycle > cycle_limit) begin
            proto_errors++;
            $display("Run did not finish within %0d cycles", cycle_limit);
            finish_run();
        end
    end

    //##########################################################
    // Stimulus table
    //##########################################################

    initial begin
        entry_t e;
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        tvalid_i     = 1'b0;
        tdata_i      = '0;
        m_coef       = '{default: '0};
        m_hist       = '{default: '{default: '0}};
        m_en         = 1'b0;
        m_shift      = '0;
        lfsr_q       = LFSR_SEED;
        cycle        = 0;
        value_errors = 0;
        proto_errors = 0;
        cycle_limit  = RESET_CYCLES + MARGIN;

        add_entry(OP_RD, 8'h00, 32'h0, 1'b0, 1);
        add_entry(OP_RD, 8'h40, 32'h0, 1'b0, 8);
        add_entry(OP_WR, 8'h40, 32'd1000, 1'b0, 1);
        add_entry(OP_WR, 8'h44, 32'h0003F830, 1'b0, 1);
        add_entry(OP_WR, 8'h48, 32'd3000, 1'b0, 1);
        add_entry(OP_WR, 8'h4C, -32'sd4000, 1'b0, 1);
        add_entry(OP_WR, 8'h50, 32'd5000, 1'b0, 1);
        add_entry(OP_WR, 8'h54, -32'sd6000, 1'b0, 1);
        add_entry(OP_WR, 8'h58, 32'd7000, 1'b0, 1);
        add_entry(OP_WR, 8'h5C, -32'sd8000, 1'b0, 1);
        add_entry(OP_RD, 8'h44, -32'sd2000, 1'b0, 1);
        add_entry(OP_RD, 8'h5C, -32'sd8000, 1'b0, 1);
        add_entry(OP_RD, 8'h60, 32'h0, 1'b1, 1);
        add_entry(OP_RD, 8'h42, 32'h0, 1'b1, 1);
        add_entry(OP_RD, 8'h04, 32'h0, 1'b1, 1);
        add_entry(OP_WR, 8'h00, 32'h0000_0001, 1'b0, 1);
        add_entry(OP_RD, 8'h00, 32'h0000_0001, 1'b0, 1);
        add_entry(OP_BURST, 8'h00, KIND_IMPULSE, 1'b0, 12);
        // Tap sum is negative, so the two channels clamp at opposite ends
        add_entry(OP_BURST, 8'h00, KIND_FULL, 1'b0, 12);
        add_entry(OP_WR, 8'h40, 32'd3, 1'b0, 1);
        add_entry(OP_WR, 8'h44, -32'sd5, 1'b0, 1);
        add_entry(OP_WR, 8'h48, 32'd7, 1'b0, 1);
        add_entry(OP_WR, 8'h4C, 32'd9, 1'b0, 1);
        add_entry(OP_WR, 8'h50, 32'd9, 1'b0, 1);
        add_entry(OP_WR, 8'h54, 32'd7, 1'b0, 1);
        add_entry(OP_WR, 8'h58, -32'sd5, 1'b0, 1);
        add_entry(OP_WR, 8'h5C, 32'd3, 1'b0, 1);
        add_entry(OP_WR, 8'h00, 32'h0000_0401, 1'b0, 1);
        add_entry(OP_RD, 8'h00, 32'h0000_0401, 1'b0, 1);
        add_entry(OP_BURST, 8'h00, KIND_RANDOM, 1'b0, 40);
        add_entry(OP_EN, 8'h00, 32'h0, 1'b0, 1);
        add_entry(OP_BURST, 8'h00, KIND_RANDOM, 1'b0, 10);
        add_entry(OP_EN, 8'h00, 32'h1, 1'b0, 1);
        add_entry(OP_BURST, 8'h00, KIND_RANDOM, 1'b0, 8);

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        @(negedge clk);
        assert (tvalid_o === 1'b0 && pready === 1'b0 && pslverr === 1'b0)
            else begin
                proto_errors++;
                $display("Outputs not idle after reset at %0t", $time);
            end
        step();

        while (table_q.size() != 0) begin
            e = table_q.pop_front();
            run_entry(e);
        end
        finish_run();
    end

endmodule

// ==== src/fir_subsys_top.sv ====
`timescale 1ns/1ps
//##########################################################
// Two-channel streaming FIR subsystem with APB coefficients
//##########################################################
`include "fir_defines.svh"

module fir_subsys_top
    import fir_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_i,

    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  apb_addr_t                   paddr_i,
    input  apb_data_t                   pwdata_i,
    output apb_data_t                   prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,

    input  logic                        tvalid_i,
    input  sample_t [`FIR_CH_NUM-1:0]   tdata_i,
    output logic                        tvalid_o,
    output sample_t [`FIR_CH_NUM-1:0]   tdata_o
);

    logic                       enable;
    shift_t                     shift;
    coef_t [`FIR_TAP_NUM-1:0]   coef;
    logic                       acc_valid;
    acc_t  [`FIR_CH_NUM-1:0]    acc_data;

    fir_coef_bank u_coef_bank (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .enable_o  (enable),
        .shift_o   (shift),
        .coef_o    (coef)
    );

    // Core latency is 4 cycles, the scaler adds one more
    fir_filter u_filter (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .tvalid_i (tvalid_i),
        .tdata_i  (tdata_i),
        .enable_i (enable),
        .coef_i   (coef),
        .tvalid_o (acc_valid),
        .tdata_o  (acc_data)
    );

    fir_output_scaler u_scaler (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .tvalid_i (acc_valid),
        .tdata_i  (acc_data),
        .shift_i  (shift),
        .tvalid_o (tvalid_o),
        .tdata_o  (tdata_o)
    );

endmodule

// ==== src/fir_output_scaler.sv ====
`timescale 1ns/1ps
//##########################################################
// Rounding right shift and saturation of each channel sum
//##########################################################
`include "fir_defines.svh"

module fir_output_scaler
    import fir_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_i,

    input  logic                        tvalid_i,
    input  acc_t    [`FIR_CH_NUM-1:0]   tdata_i,
    input  shift_t                      shift_i,

    output logic                        tvalid_o,
    output sample_t [`FIR_CH_NUM-1:0]   tdata_o
);

    // One guard bit keeps the rounding add from overflowing
    localparam int WIDE_W = `FIR_ACC_W + 1;
    localparam logic signed [WIDE_W-1:0] WIDE_ONE = 1;
    localparam logic signed [WIDE_W-1:0] SAT_MAX  = (2 ** (`FIR_DATA_W - 1)) - 1;
    localparam logic signed [WIDE_W-1:0] SAT_MIN  = -(2 ** (`FIR_DATA_W - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tvalid_o <= 1'b0;
        end else begin
            tvalid_o <= tvalid_i;
        end
    end

    for (genvar ch = 0; ch < `FIR_CH_NUM; ch++) begin : g_ch
        logic signed [WIDE_W-1:0] wide;
        logic signed [WIDE_W-1:0] shifted;
        sample_t                  sat;
        sample_t                  data_q;

        assign wide = tdata_i[ch];

        always_comb begin
            if (shift_i == '0) begin
                shifted = wide;
            end else if (shift_i >= `FIR_ACC_W) begin
                // Every possible sum rounds to zero at this shift
                shifted = '0;
            end else begin
                shifted = (wide + (WIDE_ONE << (shift_i - 1'b1))) >>> shift_i;
            end
        end

        always_comb begin
            if (shifted > SAT_MAX) begin
                sat = {1'b0, {(`FIR_DATA_W - 1){1'b1}}};
            end else if (shifted < SAT_MIN) begin
                sat = {1'b1, {(`FIR_DATA_W - 1){1'b0}}};
            end else begin
                sat = shifted[`FIR_DATA_W-1:0];
            end
        end

        always_ff @(posedge clk_i) begin
            data_q <= sat;
        end

        assign tdata_o[ch] = data_q;
    end

endmodule

// ==== fir/fir_coef_bank.sv ====
`timescale 1ns/1ps
//##########################################################
// Zero-wait APB slave with the control register and the
// coefficient bank that feeds the FIR core in parallel
//##########################################################
`include "fir_defines.svh"

module fir_coef_bank
    import fir_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_i,

    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  apb_addr_t                   paddr_i,
    input  apb_data_t                   pwdata_i,
    output apb_data_t                   prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,

    output logic                        enable_o,
    output shift_t                      shift_o,
    output coef_t   [`FIR_TAP_NUM-1:0]  coef_o
);

    localparam int IDX_W     = $clog2(`FIR_TAP_NUM);
    localparam int COEF_SPAN = 4 * `FIR_TAP_NUM;
    localparam int SIGN_W    = `FIR_APB_DW - `FIR_COEF_W;

    logic                       access;
    logic                       ctrl_hit;
    logic                       coef_hit;
    apb_addr_t                  coef_off;
    logic [IDX_W-1:0]           coef_idx;
    logic                       enable_q;
    shift_t                     shift_q;
    coef_t [`FIR_TAP_NUM-1:0]   coef_q;
    apb_data_t                  rdata;

    assign access = psel_i & penable_i;

    //##########################################################
    // Address decode
    //##########################################################

    assign ctrl_hit = (paddr_i == `FIR_REG_CTRL);
    assign coef_off = paddr_i - `FIR_REG_COEF_BASE;
    // Coefficients are word aligned, one per 32-bit slot
    assign coef_hit = (paddr_i >= `FIR_REG_COEF_BASE)
                    && (coef_off < COEF_SPAN)
                    && (paddr_i[1:0] == 2'b00);
    assign coef_idx = coef_off[IDX_W+1:2];

    //##########################################################
    // Register writes
    //##########################################################

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            enable_q <= 1'b0;
            shift_q  <= '0;
            coef_q   <= '0;
        end else if (access && pwrite_i) begin
            if (ctrl_hit) begin
                enable_q <= pwdata_i[`FIR_CTRL_EN_BIT];
                shift_q  <= pwdata_i[`FIR_CTRL_SHIFT_LSB +: `FIR_SHIFT_W];
            end
            if (coef_hit) begin
                coef_q[coef_idx] <= pwdata_i[`FIR_COEF_W-1:0];
            end
        end
    end

    // Coefficients read back sign extended
    always_comb begin
        rdata = '0;
        if (ctrl_hit) begin
            rdata[`FIR_CTRL_EN_BIT]                        = enable_q;
            rdata[`FIR_CTRL_SHIFT_LSB +: `FIR_SHIFT_W]     = shift_q;
        end else if (coef_hit) begin
            rdata = {{SIGN_W{coef_q[coef_idx][`FIR_COEF_W-1]}}, coef_q[coef_idx]};
        end
    end

    assign prdata_o  = access ? rdata : '0;
    assign pready_o  = access;
    assign pslverr_o = access & ~(ctrl_hit | coef_hit);

    assign enable_o  = enable_q;
    assign shift_o   = shift_q;
    assign coef_o    = coef_q;

endmodule

// ==== fir/fir_filter.sv ====
`timescale 1ns/1ps
//##########################################################
// Multichannel FIR core with per-channel delay lines,
// registered products and a pipelined adder tree
//##########################################################
`include "fir_defines.svh"

module fir_filter
    import fir_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_i,

    input  logic                        tvalid_i,
    input  sample_t [`FIR_CH_NUM-1:0]   tdata_i,

    input  logic                        enable_i,
    input  coef_t   [`FIR_TAP_NUM-1:0]  coef_i,

    output logic                        tvalid_o,
    output acc_t    [`FIR_CH_NUM-1:0]   tdata_o
);

    // Product register plus one register per tree level
    localparam int TREE_DEPTH = $clog2(`FIR_TAP_NUM);
    localparam int LATENCY    = 1 + TREE_DEPTH;
    localparam int NODE_NUM   = `FIR_TAP_NUM - 1;
    localparam int PROD_W     = `FIR_DATA_W + `FIR_COEF_W;

    logic             accept;
    logic [LATENCY:0] valid_d;

    // Samples arriving while disabled are dropped
    assign accept = tvalid_i & enable_i;

    //##########################################################
    // Valid pipeline
    //##########################################################

    // Bit 0 marks the edge where the sample entered the delay line
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_d <= '0;
        end else begin
            valid_d <= {valid_d[LATENCY-1:0], accept};
        end
    end

    assign tvalid_o = valid_d[LATENCY];

    //##########################################################
    // Per-channel datapath
    //##########################################################

    for (genvar ch = 0; ch < `FIR_CH_NUM; ch++) begin : g_ch
        sample_t                  delay [`FIR_TAP_NUM];
        logic signed [PROD_W-1:0] prod  [`FIR_TAP_NUM];
        // Node 0 is the root of a heap-ordered tree and node i adds nodes 2i+1 and 2i+2
        acc_t                     node  [NODE_NUM];

        // Tap 0 holds the newest sample
        always_ff @(posedge clk_i) begin
            if (rst_i) begin
                delay <= '{default: '0};
            end else if (accept) begin
                delay[0] <= tdata_i[ch];
                for (int k = 1; k < `FIR_TAP_NUM; k++) begin
                    delay[k] <= delay[k-1];
                end
            end
        end

        always_ff @(posedge clk_i) begin
            for (int k = 0; k < `FIR_TAP_NUM; k++) begin
                prod[k] <= delay[k] * coef_i[k];
            end
        end

        // Every path from a product to the root crosses TREE_DEPTH registers
        for (genvar i = 0; i < NODE_NUM; i++) begin : g_node
            if (2 * i + 1 >= NODE_NUM) begin : g_leaf
                always_ff @(posedge clk_i) begin
                    node[i] <= prod[2*i+1-NODE_NUM] + prod[2*i+2-NODE_NUM];
                end
            end else begin : g_inner
                always_ff @(posedge clk_i) begin
                    node[i] <= node[2*i+1] + node[2*i+2];
                end
            end
        end

        assign tdata_o[ch] = node[0];
    end

endmodule

// ==== common/fir_pkg.sv ====
//##########################################################
// Shared vector types of the FIR subsystem
//##########################################################
`include "fir_defines.svh"

package fir_pkg;

    // One two's complement input or output sample
    typedef logic signed [`FIR_DATA_W-1:0] sample_t;

    // One filter tap
    typedef logic signed [`FIR_COEF_W-1:0] coef_t;

    // Full precision sum of all taps of one channel
    typedef logic signed [`FIR_ACC_W-1:0] acc_t;

    // Right shift applied by the output scaler
    typedef logic [`FIR_SHIFT_W-1:0] shift_t;

    //##########################################################
    // APB
    //##########################################################

    typedef logic [`FIR_APB_AW-1:0] apb_addr_t;
    typedef logic [`FIR_APB_DW-1:0] apb_data_t;

endpackage

// ==== common/fir_defines.svh ====
//##########################################################
// FIR subsystem parameters and APB register map
//##########################################################
`ifndef FIR_DEFINES_SVH
`define FIR_DEFINES_SVH

// Datapath geometry
`define FIR_CH_NUM   2
// The adder tree needs a power of two here
`define FIR_TAP_NUM  8
`define FIR_DATA_W   16
`define FIR_COEF_W   18
// Full precision sum grows by log2 of the tap count over one product
`define FIR_ACC_W    (`FIR_DATA_W + `FIR_COEF_W + $clog2(`FIR_TAP_NUM))
`define FIR_SHIFT_W  6

// APB register map
`define FIR_APB_AW         8
`define FIR_APB_DW         32
`define FIR_REG_CTRL       8'h00
`define FIR_REG_COEF_BASE  8'h40
`define FIR_CTRL_EN_BIT    0
`define FIR_CTRL_SHIFT_LSB 8

`endif
